//--- common/rocc_dma_config.svh
// opcode, funct codes, block lengths, tag limit and memory command macros
`ifndef ROCC_DMA_CONFIG_SVH
`define ROCC_DMA_CONFIG_SVH

// custom-0 major opcode
`define ROCC_OPCODE_CUSTOM0 7'h0b

// funct field of the accepted commands
`define FUNCT_SETTING 7'd0
`define FUNCT_LOAD    7'd1
`define FUNCT_STATUS  7'd2
`define FUNCT_STORE   7'd3

// words per block, short and long mode
`define SHORT_BEATS 128
`define LONG_BEATS  1024

// tag counter wraps to zero after this value
`define TAG_LAST 63

// memory request encodings
`define MEM_CMD_READ  5'd0
`define MEM_CMD_WRITE 5'd1
`define MEM_SIZE_WORD 2'd2

// byte step between consecutive words
`define WORD_BYTES 4

`endif

//--- common/rocc_dma_pkg.sv
// shared vector typedefs, command and memory structs, transfer engine state enum
package rocc_dma_pkg;

  // widths with a meaning of their own
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [8:0]  tag_t;
  typedef logic [4:0]  mem_cmd_t;
  typedef logic [9:0]  beat_idx_t;
  typedef logic [6:0]  funct_t;
  typedef logic [4:0]  reg_idx_t;

  // instruction fields and source operands of one command
  typedef struct packed {
    logic [6:0] opcode;
    funct_t     funct;
    reg_idx_t   rd;
    logic       xd;
    word_t      rs1;
    word_t      rs2;
  } rocc_cmd_t;

  // one memory request beat
  typedef struct packed {
    addr_t      addr;
    tag_t       tag;
    mem_cmd_t   cmd;
    logic [1:0] size;
    word_t      data;
  } mem_req_t;

  // read data coming back, in request order
  typedef struct packed {
    tag_t  tag;
    word_t data;
  } mem_resp_t;

  // load engine skips the prefetch state
  typedef enum logic [1:0] {
    XFER_IDLE,
    XFER_PREFETCH,
    XFER_ACTIVE
  } xfer_state_t;

endpackage

//--- src/sample_buffer.sv
// on-chip sample buffer, one write port and one registered read port
`timescale 1ns/100ps
`include "rocc_dma_config.svh"

module sample_buffer
(
  input  logic                   clock,
  input  logic                   buf_we,
  input  rocc_dma_pkg::beat_idx_t buf_waddr,
  input  rocc_dma_pkg::word_t    buf_wdata,
  input  logic                   buf_re,
  input  rocc_dma_pkg::beat_idx_t buf_raddr,
  output rocc_dma_pkg::word_t    buf_rdata
);
  import rocc_dma_pkg::*;

  // sized for the long block
  word_t mem [0:`LONG_BEATS-1];

  always_ff @(posedge clock)
  begin
    if (buf_we)
      mem[buf_waddr] <= buf_wdata;
  end

  // output holds between enables
  always_ff @(posedge clock)
  begin
    if (buf_re)
      buf_rdata <= mem[buf_raddr];
  end

endmodule

//--- src/cmd_decoder.sv
// command decode, block length setting, transfer launch and response register
`timescale 1ns/100ps
`include "rocc_dma_config.svh"

module cmd_decoder
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    cmd_valid,
  input  rocc_dma_pkg::rocc_cmd_t cmd,
  input  logic                    busy,
  input  logic                    resp_ready,
  output logic                    cmd_ready,
  output logic                    resp_valid,
  output rocc_dma_pkg::reg_idx_t  resp_rd,
  output rocc_dma_pkg::word_t     resp_data,
  output logic                    load_start,
  output logic                    store_start,
  output rocc_dma_pkg::addr_t     base_addr,
  output logic                    long_mode
);
  import rocc_dma_pkg::*;

  logic  is_custom0;
  logic  busy_now;
  logic  launch_load;
  logic  launch_store;
  word_t beat_count;
  word_t resp_next;

  // commands are never back-pressured
  assign cmd_ready = 1'b1;

  assign is_custom0 = cmd_valid && (cmd.opcode == `ROCC_OPCODE_CUSTOM0);

  // arbiter busy lags the start pulse, so cover that gap here
  assign busy_now = busy || load_start || store_start;

  assign launch_load  = is_custom0 && (cmd.funct == `FUNCT_LOAD) && !busy_now;
  assign launch_store = is_custom0 && (cmd.funct == `FUNCT_STORE) && !busy_now;

  assign beat_count = long_mode ? word_t'(`LONG_BEATS) : word_t'(`SHORT_BEATS);

  always_comb
  begin
    resp_next = '0;
    if (is_custom0)
    begin
      case (cmd.funct)
        `FUNCT_SETTING: resp_next = word_t'(cmd.rd);
        `FUNCT_STATUS:  resp_next = {30'd0, long_mode, busy_now};
        `FUNCT_LOAD:    resp_next = launch_load ? beat_count : '0;
        `FUNCT_STORE:   resp_next = launch_store ? beat_count : '0;
        default:        resp_next = '0;
      endcase
    end
  end

  // block length setting and one-cycle start pulses
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      long_mode   <= 1'b0;
      load_start  <= 1'b0;
      store_start <= 1'b0;
    end
    else
    begin
      if (is_custom0 && (cmd.funct == `FUNCT_SETTING))
        long_mode <= cmd.rs1[0];
      load_start  <= launch_load;
      store_start <= launch_store;
    end
  end

  // base address held for the engines while they run
  always_ff @(posedge clock)
  begin
    if (launch_load || launch_store)
      base_addr <= cmd.rs1;
  end

  // response stays up until the core takes it
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      resp_valid <= 1'b0;
    else if (cmd_valid && cmd.xd)
      resp_valid <= 1'b1;
    else if (resp_ready)
      resp_valid <= 1'b0;
  end

  always_ff @(posedge clock)
  begin
    if (cmd_valid && cmd.xd)
    begin
      resp_rd   <= cmd.rd;
      resp_data <= resp_next;
    end
  end

endmodule

//--- mem_port/load_engine.sv
// load engine, read requests from memory and buffer fill from the responses
`timescale 1ns/100ps
`include "rocc_dma_config.svh"

module load_engine
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    load_start,
  input  rocc_dma_pkg::addr_t     base_addr,
  input  logic                    long_mode,
  input  logic                    req_ready,
  input  logic                    mem_resp_valid,
  input  rocc_dma_pkg::mem_resp_t mem_resp,
  output logic                    req_valid,
  output rocc_dma_pkg::mem_req_t  req,
  output logic                    buf_we,
  output rocc_dma_pkg::beat_idx_t buf_waddr,
  output rocc_dma_pkg::word_t     buf_wdata,
  output logic                    done
);
  import rocc_dma_pkg::*;

  xfer_state_t state;
  addr_t       addr;
  logic        long_q;
  beat_idx_t   issue_cnt;
  beat_idx_t   resp_cnt;
  beat_idx_t   last_beat;
  logic        req_fire;
  logic        resp_fire;

  assign last_beat = long_q ? beat_idx_t'(`LONG_BEATS - 1) : beat_idx_t'(`SHORT_BEATS - 1);
  assign req_fire  = req_valid && req_ready;
  // memory only answers reads, so every response here is ours
  assign resp_fire = mem_resp_valid && (state == XFER_ACTIVE);

  // tag is filled in by the arbiter
  assign req = '{addr: addr, tag: '0, cmd: `MEM_CMD_READ, size: `MEM_SIZE_WORD, data: '0};

  assign buf_we    = resp_fire;
  assign buf_waddr = resp_cnt;
  assign buf_wdata = mem_resp.data;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state     <= XFER_IDLE;
      req_valid <= 1'b0;
      issue_cnt <= '0;
      resp_cnt  <= '0;
      done      <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (load_start)
      begin
        state     <= XFER_ACTIVE;
        req_valid <= 1'b1;
        issue_cnt <= '0;
        resp_cnt  <= '0;
      end
      else
      begin
        if (req_fire)
        begin
          issue_cnt <= issue_cnt + 1'b1;
          if (issue_cnt == last_beat)
            req_valid <= 1'b0;
        end
        if (resp_fire)
        begin
          resp_cnt <= resp_cnt + 1'b1;
          // last word written, transfer complete
          if (resp_cnt == last_beat)
          begin
            state <= XFER_IDLE;
            done  <= 1'b1;
          end
        end
      end
    end
  end

  // address and block length of the running transfer
  always_ff @(posedge clock)
  begin
    if (load_start)
    begin
      addr   <= base_addr;
      long_q <= long_mode;
    end
    else if (req_fire)
      addr <= addr + addr_t'(`WORD_BYTES);
  end

endmodule

//--- mem_port/store_engine.sv
// store engine, buffer read-ahead and write requests to memory
`timescale 1ns/100ps
`include "rocc_dma_config.svh"

module store_engine
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    store_start,
  input  rocc_dma_pkg::addr_t     base_addr,
  input  logic                    long_mode,
  input  logic                    req_ready,
  input  rocc_dma_pkg::word_t     buf_rdata,
  output logic                    req_valid,
  output rocc_dma_pkg::mem_req_t  req,
  output logic                    buf_re,
  output rocc_dma_pkg::beat_idx_t buf_raddr,
  output logic                    done
);
  import rocc_dma_pkg::*;

  xfer_state_t state;
  addr_t       addr;
  logic        long_q;
  beat_idx_t   beat_cnt;
  beat_idx_t   last_beat;
  logic        req_fire;
  logic        last_fire;

  assign last_beat = long_q ? beat_idx_t'(`LONG_BEATS - 1) : beat_idx_t'(`SHORT_BEATS - 1);
  assign req_fire  = req_valid && req_ready;
  assign last_fire = req_fire && (beat_cnt == last_beat);

  // word 0 in the prefetch cycle, then the word after the one just sent
  assign buf_re    = (state == XFER_PREFETCH) || (req_fire && !last_fire);
  assign buf_raddr = (state == XFER_PREFETCH) ? '0 : beat_idx_t'(beat_cnt + 1'b1);

  // buffer output only moves on a read, so data holds while stalled
  assign req = '{addr: addr, tag: '0, cmd: `MEM_CMD_WRITE, size: `MEM_SIZE_WORD,
                 data: buf_rdata};

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state     <= XFER_IDLE;
      req_valid <= 1'b0;
      beat_cnt  <= '0;
      done      <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        XFER_IDLE:
        begin
          if (store_start)
          begin
            state    <= XFER_PREFETCH;
            beat_cnt <= '0;
          end
        end
        XFER_PREFETCH:
        begin
          state     <= XFER_ACTIVE;
          req_valid <= 1'b1;
        end
        default:
        begin
          if (req_fire)
            beat_cnt <= beat_cnt + 1'b1;
          if (last_fire)
          begin
            state     <= XFER_IDLE;
            req_valid <= 1'b0;
            done      <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock)
  begin
    if (store_start)
    begin
      addr   <= base_addr;
      long_q <= long_mode;
    end
    else if (req_fire)
      addr <= addr + addr_t'(`WORD_BYTES);
  end

endmodule

//--- mem_port/mem_port_arbiter.sv
// memory port arbiter, request select, tag counter, busy flag and interrupt
`timescale 1ns/100ps
`include "rocc_dma_config.svh"

module mem_port_arbiter
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   load_req_valid,
  input  rocc_dma_pkg::mem_req_t load_req,
  input  logic                   store_req_valid,
  input  rocc_dma_pkg::mem_req_t store_req,
  input  logic                   mem_req_ready,
  input  logic                   load_done,
  input  logic                   store_done,
  input  logic                   load_start,
  input  logic                   store_start,
  output logic                   load_req_ready,
  output logic                   store_req_ready,
  output logic                   mem_req_valid,
  output rocc_dma_pkg::mem_req_t mem_req,
  output logic                   busy,
  output logic                   interrupt
);
  import rocc_dma_pkg::*;

  // 1 while the load engine owns the port
  logic sel_load;
  tag_t tag;

  assign mem_req_valid   = sel_load ? load_req_valid : store_req_valid;
  assign load_req_ready  = mem_req_ready && sel_load;
  assign store_req_ready = mem_req_ready && !sel_load;

  always_comb
  begin
    mem_req     = sel_load ? load_req : store_req;
    mem_req.tag = tag;
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      sel_load  <= 1'b0;
      tag       <= '0;
      busy      <= 1'b0;
      interrupt <= 1'b0;
    end
    else
    begin
      if (load_start)
        sel_load <= 1'b1;
      else if (store_start)
        sel_load <= 1'b0;

      // fresh tag per transfer
      if (load_start || store_start)
      begin
        if (tag == tag_t'(`TAG_LAST))
          tag <= '0;
        else
          tag <= tag + 1'b1;
      end

      if (load_start || store_start)
        busy <= 1'b1;
      else if (load_done || store_done)
        busy <= 1'b0;

      interrupt <= load_done || store_done;
    end
  end

endmodule

//--- src/rocc_dma_top.sv
// top level of the block transfer accelerator, decoder, engines, arbiter and buffer
`timescale 1ns/100ps

module rocc_dma_top
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      cmd_valid,
  input  rocc_dma_pkg::rocc_cmd_t   cmd,
  output logic                      cmd_ready,
  input  logic                      resp_ready,
  output logic                      resp_valid,
  output rocc_dma_pkg::reg_idx_t    resp_rd,
  output rocc_dma_pkg::word_t       resp_data,
  input  logic                      mem_req_ready,
  output logic                      mem_req_valid,
  output rocc_dma_pkg::mem_req_t    mem_req,
  input  logic                      mem_resp_valid,
  input  rocc_dma_pkg::mem_resp_t   mem_resp,
  output logic                      busy,
  output logic                      interrupt
);
  import rocc_dma_pkg::*;

  // decoder to engines
  logic      load_start;
  logic      store_start;
  addr_t     base_addr;
  logic      long_mode;

  // engines to arbiter
  logic      load_req_valid;
  logic      load_req_ready;
  mem_req_t  load_req;
  logic      load_done;
  logic      store_req_valid;
  logic      store_req_ready;
  mem_req_t  store_req;
  logic      store_done;

  // buffer ports
  logic      buf_we;
  beat_idx_t buf_waddr;
  word_t     buf_wdata;
  logic      buf_re;
  beat_idx_t buf_raddr;
  word_t     buf_rdata;

  cmd_decoder u_cmd_decoder
  (
    .clock       (clock),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .busy        (busy),
    .resp_ready  (resp_ready),
    .cmd_ready   (cmd_ready),
    .resp_valid  (resp_valid),
    .resp_rd     (resp_rd),
    .resp_data   (resp_data),
    .load_start  (load_start),
    .store_start (store_start),
    .base_addr   (base_addr),
    .long_mode   (long_mode)
  );

  load_engine u_load_engine
  (
    .clock          (clock),
    .reset          (reset),
    .load_start     (load_start),
    .base_addr      (base_addr),
    .long_mode      (long_mode),
    .req_ready      (load_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp       (mem_resp),
    .req_valid      (load_req_valid),
    .req            (load_req),
    .buf_we         (buf_we),
    .buf_waddr      (buf_waddr),
    .buf_wdata      (buf_wdata),
    .done           (load_done)
  );

  store_engine u_store_engine
  (
    .clock       (clock),
    .reset       (reset),
    .store_start (store_start),
    .base_addr   (base_addr),
    .long_mode   (long_mode),
    .req_ready   (store_req_ready),
    .buf_rdata   (buf_rdata),
    .req_valid   (store_req_valid),
    .req         (store_req),
    .buf_re      (buf_re),
    .buf_raddr   (buf_raddr),
    .done        (store_done)
  );

  mem_port_arbiter u_mem_port_arbiter
  (
    .clock           (clock),
    .reset           (reset),
    .load_req_valid  (load_req_valid),
    .load_req        (load_req),
    .store_req_valid (store_req_valid),
    .store_req       (store_req),
    .mem_req_ready   (mem_req_ready),
    .load_done       (load_done),
    .store_done      (store_done),
    .load_start      (load_start),
    .store_start     (store_start),
    .load_req_ready  (load_req_ready),
    .store_req_ready (store_req_ready),
    .mem_req_valid   (mem_req_valid),
    .mem_req         (mem_req),
    .busy            (busy),
    .interrupt       (interrupt)
  );

  sample_buffer u_sample_buffer
  (
    .clock     (clock),
    .buf_we    (buf_we),
    .buf_waddr (buf_waddr),
    .buf_wdata (buf_wdata),
    .buf_re    (buf_re),
    .buf_raddr (buf_raddr),
    .buf_rdata (buf_rdata)
  );

endmodule

//--- verification/tb_mem_model.sv
// memory model with random request ready, in-order read responses and captured writes
`timescale 1ns/100ps
`include "rocc_dma_config.svh"

module tb_mem_model
#(
  parameter logic [31:0] READ_PATTERN = 32'h5A5A_5A5A
)
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    mem_req_valid,
  input  rocc_dma_pkg::mem_req_t  mem_req,
  output logic                    mem_req_ready,
  output logic                    mem_resp_valid,
  output rocc_dma_pkg::mem_resp_t mem_resp
);
  import rocc_dma_pkg::*;

  logic [31:0] lfsr_state;
  logic        fire;
  mem_req_t    req_q;

  // every accepted request, in order
  mem_req_t    req_log[$];
  word_t       wr_mem[addr_t];
  mem_resp_t   pending[$];

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  initial
  begin
    lfsr_state     = 32'd72749;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp       = '0;
    forever
    begin
      // request and ready are settled half a cycle before the edge
      @(negedge clock);
      fire  = mem_req_valid && mem_req_ready;
      req_q = mem_req;
      @(posedge clock);
      #1;
      mem_resp_valid = 1'b0;
      if (fire && !reset)
      begin
        req_log.push_back(req_q);
        if (req_q.cmd == `MEM_CMD_WRITE)
          wr_mem[req_q.addr] = req_q.data;
        else
          pending.push_back('{tag: req_q.tag, data: req_q.addr ^ READ_PATTERN});
      end
      // random response delay, order kept
      if (pending.size() > 0 && take_bit())
      begin
        mem_resp       = pending.pop_front();
        mem_resp_valid = 1'b1;
      end
      mem_req_ready = take_bit();
    end
  end

endmodule

//--- verification/tb_rocc_dma.sv
// testbench top, clock and reset, command and check tasks, directed tests and watchdog
`timescale 1ns/100ps
`include "rocc_dma_config.svh"

module tb_rocc_dma;
  import rocc_dma_pkg::*;

  localparam int TOTAL_BEATS     = 3 * `SHORT_BEATS + 2 * `LONG_BEATS;
  // loose bound per beat under random ready and response delay
  localparam int CYCLES_PER_BEAT = 16;
  localparam int WATCHDOG_NS     = (TOTAL_BEATS * CYCLES_PER_BEAT + 4000) * 8;

  localparam logic [31:0] READ_PATTERN = 32'h5A5A_5A5A;
  localparam addr_t BASE_A = 32'h0001_0000;
  localparam addr_t BASE_B = 32'h0002_0000;
  localparam addr_t BASE_C = 32'h0003_0000;
  localparam addr_t BASE_D = 32'h0004_0000;
  localparam addr_t BASE_E = 32'h0005_0000;

  logic      clock;
  logic      reset;
  logic      cmd_valid;
  rocc_cmd_t cmd;
  logic      cmd_ready;
  logic      resp_ready;
  logic      resp_valid;
  reg_idx_t  resp_rd;
  word_t     resp_data;
  logic      mem_req_ready;
  logic      mem_req_valid;
  mem_req_t  mem_req;
  logic      mem_resp_valid;
  mem_resp_t mem_resp;
  logic      busy;
  logic      interrupt;

  int   checks = 0;
  int   value_errors = 0;
  int   other_errors = 0;
  int   irq_count = 0;
  tag_t next_tag;

  rocc_dma_top UUT
  (
    .clock          (clock),
    .reset          (reset),
    .cmd_valid      (cmd_valid),
    .cmd            (cmd),
    .cmd_ready      (cmd_ready),
    .resp_ready     (resp_ready),
    .resp_valid     (resp_valid),
    .resp_rd        (resp_rd),
    .resp_data      (resp_data),
    .mem_req_ready  (mem_req_ready),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp       (mem_resp),
    .busy           (busy),
    .interrupt      (interrupt)
  );

  tb_mem_model #(.READ_PATTERN(READ_PATTERN)) mem_model
  (
    .clock          (clock),
    .reset          (reset),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp       (mem_resp)
  );

  initial
  begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // one count per cycle that interrupt is high
  always @(negedge clock)
  begin
    if (interrupt)
      irq_count++;
  end

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    checks++;
    if (actual !== expected)
    begin
      value_errors++;
      $display("ERR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // sends one command with xd set and returns the response data
  task automatic send_cmd(input funct_t funct, input word_t rs1, input reg_idx_t rd,
                          output word_t data);
    int waited;
    cmd_valid = 1'b1;
    cmd = '{opcode: `ROCC_OPCODE_CUSTOM0, funct: funct, rd: rd, xd: 1'b1, rs1: rs1, rs2: '0};
    @(posedge clock);
    #1;
    cmd_valid = 1'b0;
    waited = 0;
    while (!resp_valid && waited < 20)
    begin
      @(posedge clock);
      #1;
      waited++;
    end
    data = '0;
    if (!resp_valid)
    begin
      other_errors++;
      $display("no response came back for funct %0d", funct);
    end
    else
    begin
      check_value("resp_rd", 32'(resp_rd), 32'(rd));
      data = resp_data;
    end
    resp_ready = 1'b1;
    @(posedge clock);
    #1;
    resp_ready = 1'b0;
  endtask

  task automatic start_transfer(input funct_t funct, input addr_t base, input int beats,
                                output int start_idx, output int irq_before);
    word_t data;
    start_idx  = mem_model.req_log.size();
    irq_before = irq_count;
    next_tag   = (next_tag == tag_t'(`TAG_LAST)) ? '0 : next_tag + 1'b1;
    send_cmd(funct, base, 5'd1, data);
    check_value("transfer resp_data", data, word_t'(beats));
  endtask

  // waits for the interrupt, then checks every request of the transfer
  task automatic finish_transfer(input int start_idx, input int irq_before, input int beats,
                                 input mem_cmd_t exp_cmd, input addr_t base,
                                 input addr_t src_base);
    int       waited;
    int       i;
    mem_req_t req;
    addr_t    exp_addr;
    word_t    exp_data;
    waited = 0;
    while (irq_count == irq_before && waited < beats * CYCLES_PER_BEAT + 200)
    begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (irq_count == irq_before)
    begin
      other_errors++;
      $display("transfer at %h never raised its interrupt", base);
    end
    repeat (4) @(posedge clock);
    #1;
    check_value("interrupt pulses", irq_count - irq_before, 1);
    check_value("busy", 32'(busy), 32'd0);
    check_value("request count", mem_model.req_log.size() - start_idx, beats);
    for (i = 0; i < beats && start_idx + i < mem_model.req_log.size(); i++)
    begin
      req      = mem_model.req_log[start_idx + i];
      exp_addr = base + addr_t'(i * `WORD_BYTES);
      exp_data = (src_base + addr_t'(i * `WORD_BYTES)) ^ READ_PATTERN;
      check_value($sformatf("req[%0d].addr", i), req.addr, exp_addr);
      check_value($sformatf("req[%0d].cmd", i), 32'(req.cmd), 32'(exp_cmd));
      check_value($sformatf("req[%0d].size", i), 32'(req.size), 32'(`MEM_SIZE_WORD));
      check_value($sformatf("req[%0d].tag", i), 32'(req.tag), 32'(next_tag));
      if (exp_cmd == `MEM_CMD_WRITE)
      begin
        check_value($sformatf("req[%0d].data", i), req.data, exp_data);
        if (!mem_model.wr_mem.exists(exp_addr))
        begin
          other_errors++;
          $display("memory at %h was never written", exp_addr);
        end
        else
          check_value("stored word", mem_model.wr_mem[exp_addr], exp_data);
      end
    end
  endtask

  task automatic test_reset_and_settings();
    word_t data;
    check_value("resp_valid", 32'(resp_valid), 32'd0);
    check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);
    check_value("busy", 32'(busy), 32'd0);
    check_value("interrupt", 32'(interrupt), 32'd0);
    check_value("cmd_ready", 32'(cmd_ready), 32'd1);
    send_cmd(`FUNCT_SETTING, 32'd0, 5'd5, data);
    check_value("settings resp_data", data, 32'd5);
  endtask

  task automatic test_short_load();
    int start_idx;
    int irq_before;
    start_transfer(`FUNCT_LOAD, BASE_A, `SHORT_BEATS, start_idx, irq_before);
    finish_transfer(start_idx, irq_before, `SHORT_BEATS, `MEM_CMD_READ, BASE_A, BASE_A);
  endtask

  task automatic test_short_store();
    int start_idx;
    int irq_before;
    start_transfer(`FUNCT_STORE, BASE_B, `SHORT_BEATS, start_idx, irq_before);
    finish_transfer(start_idx, irq_before, `SHORT_BEATS, `MEM_CMD_WRITE, BASE_B, BASE_A);
  endtask

  task automatic test_busy_status();
    int    start_idx;
    int    irq_before;
    word_t data;
    start_transfer(`FUNCT_LOAD, BASE_C, `SHORT_BEATS, start_idx, irq_before);
    send_cmd(`FUNCT_STATUS, 32'd0, 5'd2, data);
    check_value("status while busy", data, 32'd1);
    // refused, so no tag is used
    send_cmd(`FUNCT_LOAD, BASE_D, 5'd3, data);
    check_value("load while busy resp_data", data, 32'd0);
    finish_transfer(start_idx, irq_before, `SHORT_BEATS, `MEM_CMD_READ, BASE_C, BASE_C);
    send_cmd(`FUNCT_SETTING, 32'd1, 5'd4, data);
    check_value("settings resp_data", data, 32'd4);
    send_cmd(`FUNCT_STATUS, 32'd0, 5'd2, data);
    check_value("status in long mode", data, 32'd2);
  endtask

  task automatic test_long_transfers();
    int start_idx;
    int irq_before;
    start_transfer(`FUNCT_LOAD, BASE_D, `LONG_BEATS, start_idx, irq_before);
    finish_transfer(start_idx, irq_before, `LONG_BEATS, `MEM_CMD_READ, BASE_D, BASE_D);
    start_transfer(`FUNCT_STORE, BASE_E, `LONG_BEATS, start_idx, irq_before);
    finish_transfer(start_idx, irq_before, `LONG_BEATS, `MEM_CMD_WRITE, BASE_E, BASE_D);
  endtask

  initial
  begin
    reset      = 1'b1;
    cmd_valid  = 1'b0;
    cmd        = '0;
    resp_ready = 1'b0;
    next_tag   = '0;
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;
    @(posedge clock);
    #1;
    test_reset_and_settings();
    test_short_load();
    test_short_store();
    test_busy_status();
    test_long_transfers();
    $display("checks: %0d, value errors: %0d, other failures: %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- rocc_dma.f
+incdir+common
common/rocc_dma_pkg.sv
src/sample_buffer.sv
src/cmd_decoder.sv
mem_port/load_engine.sv
mem_port/store_engine.sv
mem_port/mem_port_arbiter.sv
src/rocc_dma_top.sv
verification/tb_mem_model.sv
verification/tb_rocc_dma.sv

//--- Makefile
TOP = tb_rocc_dma
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f rocc_dma.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
